// File: design/sounder_defines.svh
// Channel sounder constants
// Serial register map, legal PN degrees and LFSR feedback masks
// Tap masks are for a right-shifting LFSR with output at bit 0
// Feedback parity of (state & mask) enters bit degree-1

`ifndef SOUNDER_DEFINES_SVH
`define SOUNDER_DEFINES_SVH

// Serial bus addresses
`define SND_ADDR_CTRL 7'd80
`define SND_ADDR_AMPL 7'd81

// Legal PN degree range
`define SND_DEG_MIN   4'd4
`define SND_DEG_MAX   4'd10

// Degree loaded by reset
`define SND_DEG_RESET 4'd4

// Primitive polynomial taps, bit i set means term x^i of the recurrence
// x^4 + x + 1
`define SND_TAPS_4    10'h003
// x^5 + x^2 + 1
`define SND_TAPS_5    10'h005
// x^6 + x + 1
`define SND_TAPS_6    10'h003
// x^7 + x + 1
`define SND_TAPS_7    10'h003
// x^8 + x^4 + x^3 + x^2 + 1
`define SND_TAPS_8    10'h01D
// x^9 + x^4 + 1
`define SND_TAPS_9    10'h011
// x^10 + x^3 + 1
`define SND_TAPS_10   10'h009

`endif

// File: design/sounder_pkg.sv
// Channel sounder shared types
// Sample word and the two decodings of the 32-bit serial data word

package sounder_pkg;

   // One I or Q sample, two's complement
   typedef logic signed [15:0] sample_t;

   // Control register layout
   // Bit 0 tx enable, bit 1 rx enable, bits 7..4 PN degree
   typedef struct packed {
      logic [23:0] rsvd_hi;
      logic [3:0]  degree;
      logic [1:0]  rsvd_lo;
      logic        rx_en;
      logic        tx_en;
   } ctrl_view_t;

   // Amplitude register layout
   // Low half is the chip amplitude, upper half unused
   typedef struct packed {
      logic [15:0] rsvd;
      sample_t     amplitude;
   } ampl_view_t;

   // Same serial word, decoded by address
   typedef union packed {
      ctrl_view_t ctrl;
      ampl_view_t ampl;
   } reg_word_u;

endpackage

// File: design/sounder_regs.sv
// Sounder register block
// Decodes parallel serial-bus writes into the control levels
// Holds tx/rx enables, PN degree and chip amplitude
// Control writes with an out-of-range degree keep the old degree

`timescale 1ns/1ns
`include "sounder_defines.svh"

module sounder_regs (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic [6:0]           saddr_i,
   input  logic [31:0]          sdata_i,
   input  logic                 s_strobe_i,
   output logic                 tx_en_o,
   output logic                 rx_en_o,
   output logic [3:0]           degree_o,
   output sounder_pkg::sample_t amplitude_o
);

   // Data word seen through either register view
   sounder_pkg::reg_word_u word;
   logic                   ctrl_wr;
   logic                   ampl_wr;
   logic                   deg_legal;

   assign word = sdata_i;

   // Address decode, qualified by the bus strobe
   assign ctrl_wr = s_strobe_i && (saddr_i == `SND_ADDR_CTRL);
   assign ampl_wr = s_strobe_i && (saddr_i == `SND_ADDR_AMPL);

   // Degree field within 4..10
   assign deg_legal = (word.ctrl.degree >= `SND_DEG_MIN) &&
                      (word.ctrl.degree <= `SND_DEG_MAX);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         tx_en_o     <= 1'b0;
         rx_en_o     <= 1'b0;
         degree_o    <= `SND_DEG_RESET;
         amplitude_o <= '0;
      end else begin
         if (ctrl_wr) begin
            tx_en_o <= word.ctrl.tx_en;
            rx_en_o <= word.ctrl.rx_en;
            // Illegal degree dropped, enables still take effect
            if (deg_legal) begin
               degree_o <= word.ctrl.degree;
            end
         end
         if (ampl_wr) begin
            amplitude_o <= word.ampl.amplitude;
         end
      end
   end

   // Transmitter and correlator index taps and periods by this value
   a_degree_range : assert property (
      @(posedge clk_i) disable iff (rst_i)
      (degree_o >= `SND_DEG_MIN) && (degree_o <= `SND_DEG_MAX)
   ) else $error("sounder_regs: degree out of range");

endmodule

// File: design/pn_transmitter.sv
// PN transmitter
// Maximal-length LFSR chip generator, degree chosen at run time
// Each transmit strobe emits one chip as +/- amplitude on I, Q idle
// LFSR restarts from all ones on disable or degree change

`timescale 1ns/1ns
`include "sounder_defines.svh"

module pn_transmitter (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 tx_strobe_i,
   input  logic                 tx_en_i,
   input  logic [3:0]           degree_i,
   input  sounder_pkg::sample_t amplitude_i,
   output sounder_pkg::sample_t tx_i_o,
   output sounder_pkg::sample_t tx_q_o,
   output logic                 chip_o
);

   logic [9:0] lfsr;
   logic [9:0] lfsr_next;
   logic [9:0] taps;
   logic [9:0] seed;
   logic [3:0] degree_q;
   logic       reload;
   logic       feedback;

   // Tap mask per degree
   always_comb begin
      case (degree_i)
         4'd5:    taps = `SND_TAPS_5;
         4'd6:    taps = `SND_TAPS_6;
         4'd7:    taps = `SND_TAPS_7;
         4'd8:    taps = `SND_TAPS_8;
         4'd9:    taps = `SND_TAPS_9;
         4'd10:   taps = `SND_TAPS_10;
         default: taps = `SND_TAPS_4;
      endcase
   end

   // All ones in the low degree bits
   assign seed = ~(10'h3FF << degree_i);

   // Restart on disable or on the first cycle of a new degree
   assign reload = !tx_en_i || (degree_i != degree_q);

   // Fibonacci step, parity of tapped bits enters the top active bit
   assign feedback = ^(lfsr & taps);
   always_comb begin
      lfsr_next = lfsr >> 1;
      lfsr_next[degree_i - 4'd1] = feedback;
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         lfsr     <= ~(10'h3FF << `SND_DEG_RESET);
         degree_q <= `SND_DEG_RESET;
         chip_o   <= 1'b1;
         tx_i_o   <= '0;
      end else begin
         degree_q <= degree_i;
         if (reload) begin
            lfsr   <= seed;
            chip_o <= 1'b1;
            tx_i_o <= '0;
         end else if (tx_strobe_i) begin
            lfsr   <= lfsr_next;
            chip_o <= lfsr[0];
            // Chip 1 maps to +A, chip 0 to -A
            tx_i_o <= lfsr[0] ? amplitude_i : -amplitude_i;
         end
      end
   end

   // Q rail carries nothing in this sounder
   assign tx_q_o = '0;

   // Zero state would lock the generator
   a_lfsr_live : assert property (
      @(posedge clk_i) disable iff (rst_i)
      tx_en_i |-> (lfsr != '0)
   ) else $error("pn_transmitter: LFSR stuck at zero");

endmodule

// File: design/impulse_correlator.sv
// Zero-lag impulse correlator
// Multiplies each received I/Q sample by the current chip sign
// Sums over one PN period of 2^degree-1 receive strobes
// At period end emits the sums scaled down by 2^degree, with a strobe
// Disable or a degree change restarts the period

`timescale 1ns/1ns
`include "sounder_defines.svh"

module impulse_correlator (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 rx_strobe_i,
   input  logic                 rx_en_i,
   input  logic [3:0]           degree_i,
   input  logic                 chip_i,
   input  sounder_pkg::sample_t rx_adc_i_i,
   input  sounder_pkg::sample_t rx_adc_q_i,
   output sounder_pkg::sample_t rx_imp_i_o,
   output sounder_pkg::sample_t rx_imp_q_o,
   output logic                 rx_strobe_o
);

   // Room for 1023 full-scale samples
   logic signed [25:0] acc_i;
   logic signed [25:0] acc_q;
   logic signed [25:0] samp_i;
   logic signed [25:0] samp_q;
   logic signed [25:0] sum_i;
   logic signed [25:0] sum_q;
   logic signed [25:0] scaled_i;
   logic signed [25:0] scaled_q;
   logic [9:0]         count;
   logic [9:0]         period_len;
   logic [3:0]         degree_q;
   logic               restart;
   logic               period_end;

   // Sign extend the samples
   assign samp_i = rx_adc_i_i;
   assign samp_q = rx_adc_q_i;

   // Chip 1 adds, chip 0 subtracts
   assign sum_i = chip_i ? (acc_i + samp_i) : (acc_i - samp_i);
   assign sum_q = chip_i ? (acc_q + samp_q) : (acc_q - samp_q);

   // Divide by 2^degree, sign kept
   assign scaled_i = sum_i >>> degree_i;
   assign scaled_q = sum_q >>> degree_i;

   // 2^degree - 1 samples per period
   assign period_len = ~(10'h3FF << degree_i);

   // This strobe is the last one of the period
   assign period_end = (count + 10'd1) == period_len;

   assign restart = !rx_en_i || (degree_i != degree_q);

   // Control path, counter and accumulators
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         acc_i       <= '0;
         acc_q       <= '0;
         count       <= '0;
         degree_q    <= `SND_DEG_RESET;
         rx_strobe_o <= 1'b0;
      end else begin
         degree_q    <= degree_i;
         rx_strobe_o <= 1'b0;
         if (restart) begin
            acc_i <= '0;
            acc_q <= '0;
            count <= '0;
         end else if (rx_strobe_i) begin
            if (period_end) begin
               acc_i       <= '0;
               acc_q       <= '0;
               count       <= '0;
               rx_strobe_o <= 1'b1;
            end else begin
               acc_i <= sum_i;
               acc_q <= sum_q;
               count <= count + 10'd1;
            end
         end
      end
   end

   // Result registers, valid with rx_strobe_o
   always_ff @(posedge clk_i) begin
      if (!restart && rx_strobe_i && period_end) begin
         rx_imp_i_o <= scaled_i[15:0];
         rx_imp_q_o <= scaled_q[15:0];
      end
   end

   // Shortest period is 15 strobes, so pulses never touch
   a_strobe_pulse : assert property (
      @(posedge clk_i) disable iff (rst_i)
      rx_strobe_o |=> !rx_strobe_o
   ) else $error("impulse_correlator: rx_strobe_o held two cycles");

endmodule

// File: design/dac_interface.sv
// DAC interface
// Interleaves I and Q onto one 16-bit DAC bus
// Sync high marks the I word, the Q word follows next cycle
// Bus holds Q until the next capture, zero while disabled

`timescale 1ns/1ns

module dac_interface (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 ena_i,
   input  logic                 strobe_i,
   input  sounder_pkg::sample_t tx_i_i,
   input  sounder_pkg::sample_t tx_q_i,
   output logic [15:0]          tx_data_o,
   output logic                 tx_sync_o
);

   // Q waits one cycle behind I
   sounder_pkg::sample_t q_hold;
   // High on the cycle I is on the bus
   logic                 phase;

   always_ff @(posedge clk_i) begin
      if (rst_i || !ena_i) begin
         tx_data_o <= '0;
         tx_sync_o <= 1'b0;
         phase     <= 1'b0;
      end else if (strobe_i) begin
         // Capture the sample present now, I goes out first
         tx_data_o <= tx_i_i;
         tx_sync_o <= 1'b1;
         phase     <= 1'b1;
      end else if (phase) begin
         tx_data_o <= q_hold;
         tx_sync_o <= 1'b0;
         phase     <= 1'b0;
      end
   end

   // Q capture register
   always_ff @(posedge clk_i) begin
      if (ena_i && strobe_i) begin
         q_hold <= tx_q_i;
      end
   end

   // Back-to-back strobes would drop the Q slot
   a_strobe_spacing : assert property (
      @(posedge clk_i) disable iff (rst_i)
      strobe_i |=> !strobe_i
   ) else $error("dac_interface: transmit strobes less than two cycles apart");

endmodule

// File: design/sounder_top.sv
// Channel sounder top level
// Register block sets enables, PN degree and amplitude
// Transmitter feeds the DAC interleaver and shares its chip
// with the receive correlator

`timescale 1ns/1ns

module sounder_top (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic [6:0]           saddr_i,
   input  logic [31:0]          sdata_i,
   input  logic                 s_strobe_i,
   input  logic                 tx_strobe_i,
   input  logic                 rx_strobe_i,
   input  sounder_pkg::sample_t rx_adc_i_i,
   input  sounder_pkg::sample_t rx_adc_q_i,
   output logic [15:0]          tx_data_o,
   output logic                 tx_sync_o,
   output sounder_pkg::sample_t rx_imp_i_o,
   output sounder_pkg::sample_t rx_imp_q_o,
   output logic                 rx_strobe_o
);

   logic                 tx_en;
   logic                 rx_en;
   logic [3:0]           degree;
   sounder_pkg::sample_t amplitude;
   sounder_pkg::sample_t tx_i;
   sounder_pkg::sample_t tx_q;
   // Current chip, used as the correlator sign
   logic                 chip;

   sounder_regs i_regs (
      .clk_i(clk_i), .rst_i(rst_i),
      .saddr_i(saddr_i), .sdata_i(sdata_i), .s_strobe_i(s_strobe_i),
      .tx_en_o(tx_en), .rx_en_o(rx_en), .degree_o(degree), .amplitude_o(amplitude)
   );

   pn_transmitter i_tx (
      .clk_i(clk_i), .rst_i(rst_i),
      .tx_strobe_i(tx_strobe_i), .tx_en_i(tx_en), .degree_i(degree),
      .amplitude_i(amplitude),
      .tx_i_o(tx_i), .tx_q_o(tx_q), .chip_o(chip)
   );

   impulse_correlator i_corr (
      .clk_i(clk_i), .rst_i(rst_i),
      .rx_strobe_i(rx_strobe_i), .rx_en_i(rx_en), .degree_i(degree), .chip_i(chip),
      .rx_adc_i_i(rx_adc_i_i), .rx_adc_q_i(rx_adc_q_i),
      .rx_imp_i_o(rx_imp_i_o), .rx_imp_q_o(rx_imp_q_o), .rx_strobe_o(rx_strobe_o)
   );

   dac_interface i_dac (
      .clk_i(clk_i), .rst_i(rst_i),
      .ena_i(tx_en), .strobe_i(tx_strobe_i), .tx_i_i(tx_i), .tx_q_i(tx_q),
      .tx_data_o(tx_data_o), .tx_sync_o(tx_sync_o)
   );

endmodule

// File: tests/tb_sounder_model.svh
// Channel sounder reference model
// Tracks register state, PN chips and correlation sums
// Queues hold the expected DAC I words and correlator results

`ifndef TB_SOUNDER_MODEL_SVH
`define TB_SOUNDER_MODEL_SVH

`include "sounder_defines.svh"

logic [9:0]           m_lfsr;
int                   m_deg;
sounder_pkg::sample_t m_amp;
// I value of the last chip, goes out on the next strobe
sounder_pkg::sample_t m_prev_i;
logic                 m_tx_en;
logic                 m_rx_en;
logic                 m_chip;
int                   m_acc_i;
int                   m_acc_q;
int                   m_count;
sounder_pkg::sample_t dac_exp[$];
sounder_pkg::sample_t imp_exp_i[$];
sounder_pkg::sample_t imp_exp_q[$];

function automatic logic [9:0] taps_for(input int deg);
   case (deg)
      5:       return `SND_TAPS_5;
      6:       return `SND_TAPS_6;
      7:       return `SND_TAPS_7;
      8:       return `SND_TAPS_8;
      9:       return `SND_TAPS_9;
      10:      return `SND_TAPS_10;
      default: return `SND_TAPS_4;
   endcase
endfunction

// All ones in the low degree bits, I output idle
task automatic restart_chips();
   m_lfsr   = 10'((1 << m_deg) - 1);
   m_chip   = 1'b1;
   m_prev_i = '0;
endtask

task automatic clear_sums();
   m_acc_i = 0;
   m_acc_q = 0;
   m_count = 0;
endtask

task automatic reset_model();
   m_deg   = 4;
   m_amp   = '0;
   m_tx_en = 1'b0;
   m_rx_en = 1'b0;
   restart_chips();
   clear_sums();
endtask

task automatic apply_write(input logic [6:0] addr, input logic [31:0] data);
   int new_deg;
   new_deg = int'(data[7:4]);
   if (addr == `SND_ADDR_CTRL) begin
      m_tx_en = data[0];
      m_rx_en = data[1];
      // Legal new degree restarts both sides
      if (new_deg >= 4 && new_deg <= 10 && new_deg != m_deg) begin
         m_deg = new_deg;
         restart_chips();
         clear_sums();
      end
      if (!m_tx_en) begin
         restart_chips();
      end
      if (!m_rx_en) begin
         clear_sums();
      end
   end else if (addr == `SND_ADDR_AMPL) begin
      m_amp = data[15:0];
   end
endtask

// One transmit strobe, DAC shows the previous I
task automatic step_tx();
   logic [9:0] next;
   if (m_tx_en) begin
      dac_exp.push_back(m_prev_i);
      m_chip   = m_lfsr[0];
      m_prev_i = m_chip ? m_amp : -m_amp;
      next = m_lfsr >> 1;
      next[m_deg - 1] = ^(m_lfsr & taps_for(m_deg));
      m_lfsr = next;
   end
endtask

// One receive strobe, sign from the chip held now
task automatic step_rx(input sounder_pkg::sample_t si, input sounder_pkg::sample_t sq);
   int period;
   period = (1 << m_deg) - 1;
   if (m_rx_en) begin
      m_acc_i = m_chip ? m_acc_i + si : m_acc_i - si;
      m_acc_q = m_chip ? m_acc_q + sq : m_acc_q - sq;
      m_count++;
      if (m_count == period) begin
         imp_exp_i.push_back(sounder_pkg::sample_t'(m_acc_i >>> m_deg));
         imp_exp_q.push_back(sounder_pkg::sample_t'(m_acc_q >>> m_deg));
         clear_sums();
      end
   end
endtask

`endif

// File: tests/tb_sounder.sv
// Channel sounder testbench
// Random transmit and receive strobes from a fixed seed
// Monitor compares the DAC bus and correlator results with the model

`timescale 1ns/1ns
`include "sounder_defines.svh"

module tb_sounder;

   // Cycle budget per test, watchdog allows twice the total
   localparam int TEST_CYCLES = 150 + 350 + 300 + 350 + 900 + 250;
   localparam int WATCHDOG_NS = TEST_CYCLES * 10 * 2;

   logic                 clk_i;
   logic                 rst_i;
   logic [6:0]           saddr_i;
   logic [31:0]          sdata_i;
   logic                 s_strobe_i;
   logic                 tx_strobe_i;
   logic                 rx_strobe_i;
   sounder_pkg::sample_t rx_adc_i_i;
   sounder_pkg::sample_t rx_adc_q_i;
   logic [15:0]          tx_data_o;
   logic                 tx_sync_o;
   sounder_pkg::sample_t rx_imp_i_o;
   sounder_pkg::sample_t rx_imp_q_o;
   logic                 rx_strobe_o;

   integer seed;
   int     errors;
   int     test_errors;
   int     tests_passed;
   int     tests_failed;
   int     dac_words;
   int     pulses;

   `include "tb_sounder_model.svh"

   sounder_top i_dut (
      .clk_i(clk_i), .rst_i(rst_i),
      .saddr_i(saddr_i), .sdata_i(sdata_i), .s_strobe_i(s_strobe_i),
      .tx_strobe_i(tx_strobe_i), .rx_strobe_i(rx_strobe_i),
      .rx_adc_i_i(rx_adc_i_i), .rx_adc_q_i(rx_adc_q_i),
      .tx_data_o(tx_data_o), .tx_sync_o(tx_sync_o),
      .rx_imp_i_o(rx_imp_i_o), .rx_imp_q_o(rx_imp_q_o), .rx_strobe_o(rx_strobe_o)
   );

   always #5 clk_i = ~clk_i;

   task automatic check_value(input logic signed [31:0] observed,
                              input logic signed [31:0] expected, input string what);
      if (observed !== expected) begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s, got %0d, expected %0d",
                  $time, what, observed, expected);
      end
   endtask

   task automatic settle(input int n);
      repeat (n) @(negedge clk_i);
   endtask

   // One bus write, then a quiet cycle for the reload
   task automatic write_reg(input logic [6:0] addr, input logic [31:0] data);
      @(posedge clk_i);
      saddr_i     <= addr;
      sdata_i     <= data;
      s_strobe_i  <= 1'b1;
      tx_strobe_i <= 1'b0;
      rx_strobe_i <= 1'b0;
      apply_write(addr, data);
      @(posedge clk_i);
      s_strobe_i <= 1'b0;
      @(posedge clk_i);
   endtask

   // Tx strobes 2 to 5 cycles apart, rx strobes on about 3 of 4 cycles
   task automatic run_traffic(input int n_tx, input int n_rx);
      int                   tx_sent;
      int                   rx_sent;
      int                   tx_wait;
      logic                 do_tx;
      logic                 do_rx;
      sounder_pkg::sample_t si;
      sounder_pkg::sample_t sq;
      tx_sent = 0;
      rx_sent = 0;
      tx_wait = 0;
      while (tx_sent < n_tx || rx_sent < n_rx) begin
         do_tx = (tx_sent < n_tx) && (tx_wait == 0);
         do_rx = (rx_sent < n_rx) && (({$random(seed)} % 4) != 0);
         si = sounder_pkg::sample_t'($random(seed));
         sq = sounder_pkg::sample_t'($random(seed));
         @(posedge clk_i);
         tx_strobe_i <= do_tx;
         rx_strobe_i <= do_rx;
         rx_adc_i_i  <= si;
         rx_adc_q_i  <= sq;
         // Correlator sees the chip from before this tx strobe
         if (do_rx) begin
            step_rx(si, sq);
            rx_sent++;
         end
         if (do_tx) begin
            step_tx();
            tx_sent++;
            tx_wait = 1 + ({$random(seed)} % 4);
         end else if (tx_wait > 0) begin
            tx_wait--;
         end
      end
      @(posedge clk_i);
      tx_strobe_i <= 1'b0;
      rx_strobe_i <= 1'b0;
   endtask

   task automatic end_test(input string name);
      settle(4);
      check_value(dac_exp.size(), 0, "DAC words never seen");
      check_value(imp_exp_i.size(), 0, "correlator results never seen");
      if (errors == test_errors) begin
         tests_passed++;
         $display("[%0t ns] %s: ok", $time, name);
      end else begin
         tests_failed++;
         $display("[%0t ns] %s: FAILED, %0d errors", $time, name, errors - test_errors);
      end
      test_errors = errors;
   endtask

   // Outputs sampled mid-cycle, away from the drive edge
   always @(negedge clk_i) begin
      if (!rst_i) begin
         if (tx_sync_o === 1'b1) begin
            dac_words++;
            if (dac_exp.size() == 0) begin
               errors++;
               $display("ERROR at %0t ns: DAC sync marker with no sample expected", $time);
            end else begin
               check_value($signed(tx_data_o), dac_exp.pop_front(), "DAC I word");
            end
         end else begin
            // Q slot, hold and disabled bus are all zero
            check_value($signed(tx_data_o), 0, "DAC bus outside the I slot");
         end
         if (rx_strobe_o === 1'b1) begin
            pulses++;
            if (imp_exp_i.size() == 0) begin
               errors++;
               $display("ERROR at %0t ns: rx_strobe_o pulsed before a full period", $time);
            end else begin
               check_value(rx_imp_i_o, imp_exp_i.pop_front(), "correlator I sum");
               check_value(rx_imp_q_o, imp_exp_q.pop_front(), "correlator Q sum");
            end
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("TIMEOUT: run did not finish within %0d ns", WATCHDOG_NS);
      $display("test failed");
      $finish;
   end

   initial begin
      clk_i        = 1'b0;
      rst_i        = 1'b1;
      saddr_i      = '0;
      sdata_i      = '0;
      s_strobe_i   = 1'b0;
      tx_strobe_i  = 1'b0;
      rx_strobe_i  = 1'b0;
      rx_adc_i_i   = '0;
      rx_adc_q_i   = '0;
      seed         = 32'h8e27_dd3a;
      errors       = 0;
      test_errors  = 0;
      tests_passed = 0;
      tests_failed = 0;
      dac_words    = 0;
      pulses       = 0;
      reset_model();
      repeat (4) @(posedge clk_i);
      rst_i <= 1'b0;

      // Idle after reset, stray addresses ignored
      settle(2);
      check_value($signed(tx_data_o), 0, "DAC bus after reset");
      check_value(tx_sync_o, 0, "DAC sync after reset");
      write_reg(7'd82, 32'hFFFF_FFFF);
      write_reg(7'd0, 32'h0000_0053);
      run_traffic(10, 20);
      settle(50);
      check_value(pulses, 0, "rx_strobe_o pulses while idle");
      check_value(dac_words, 0, "DAC words while idle");
      end_test("reset and unused addresses");

      // Two periods of 31 chips at amplitude 1000
      write_reg(`SND_ADDR_AMPL, 32'd1000);
      write_reg(`SND_ADDR_CTRL, 32'h0000_0051);
      dac_words = 0;
      run_traffic(62, 0);
      settle(4);
      check_value(dac_words, 62, "DAC words over two periods");
      end_test("PN transmit at degree 5");

      // New amplitude mid-run, chip sequence runs on
      run_traffic(15, 0);
      write_reg(`SND_ADDR_AMPL, {16'h0, 16'($random(seed))});
      run_traffic(30, 0);
      end_test("amplitude change mid-run");

      // Three correlation periods of 63 samples
      write_reg(`SND_ADDR_CTRL, 32'h0000_0063);
      pulses = 0;
      run_traffic(20, 189);
      settle(4);
      check_value(pulses, 3, "correlator periods at degree 6");
      end_test("correlator at degree 6");

      // Degree 4, illegal 12, then 9
      write_reg(`SND_ADDR_CTRL, 32'h0000_0043);
      pulses = 0;
      run_traffic(10, 30);
      write_reg(`SND_ADDR_CTRL, 32'h0000_00C3);
      run_traffic(10, 30);
      settle(4);
      check_value(pulses, 4, "periods at degree 4 across the illegal write");
      write_reg(`SND_ADDR_CTRL, 32'h0000_0093);
      pulses = 0;
      run_traffic(20, 511);
      settle(4);
      check_value(pulses, 1, "period at degree 9");
      end_test("degree changes");

      // Disable mid-period, then a full new period
      write_reg(`SND_ADDR_CTRL, 32'h0000_0053);
      run_traffic(10, 20);
      write_reg(`SND_ADDR_CTRL, 32'h0000_0050);
      pulses    = 0;
      dac_words = 0;
      run_traffic(10, 40);
      settle(4);
      check_value(pulses, 0, "rx_strobe_o while disabled");
      check_value(dac_words, 0, "DAC words while disabled");
      write_reg(`SND_ADDR_CTRL, 32'h0000_0053);
      run_traffic(10, 30);
      settle(4);
      check_value(pulses, 0, "rx_strobe_o before a full new period");
      run_traffic(0, 1);
      settle(4);
      check_value(pulses, 1, "rx_strobe_o after a full new period");
      end_test("disable and re-enable");

      $display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
      if (errors == 0 && tests_failed == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// File: tb.f
+incdir+design
+incdir+tests
design/sounder_pkg.sv
design/sounder_regs.sv
design/pn_transmitter.sv
design/impulse_correlator.sv
design/dac_interface.sv
design/sounder_top.sv
tests/tb_sounder.sv

// File: run.sh
#!/bin/sh
# Build and run the channel sounder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_sounder -f tb.f -o sim_sounder

out=$(./obj_dir/sim_sounder)
echo "$out"

# Pass only when the testbench reports it
echo "$out" | grep -qx "test passed"
